/* video_board.f */
src/video_pkg.sv
src/video_timing.sv
src/video_regs.sv
src/tile_layer.sv
src/layer_mixer.sv
src/palette_out.sv
src/video_board.sv
tests/video_board_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= video_board_tb
RTL_TOP ?= video_board
FILELIST ?= video_board.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing --assert
JOBS ?= 4
PASS_MSG ?= ALL TESTS PASSED

SOURCES := $(shell cat $(FILELIST))
RTL_SOURCES := $(filter src/%,$(SOURCES))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SOURCES)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* tests/video_board_tb.sv */
`default_nettype none

module video_board_tb import video_pkg::*; ;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 20;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam int TILE_W = H_ACTIVE / TILE_COLS;
	localparam int TILE_H = V_ACTIVE / TILE_ROWS;
	localparam int NUM_ROWS = 7;
	// two bus cycles per write, plus reset and slack
	localparam int SETUP_CYCLES = 2 * (NUM_LAYERS * MAP_ENTRIES + PAL_ENTRIES) + 200;
	// each row can wait almost a frame for vblank, then scans one
	localparam longint WATCHDOG_NS =
		longint'((2 * NUM_ROWS + 3) * FRAME_CYCLES + SETUP_CYCLES) * CLK_PERIOD;

	// register setup and four probe points per row
	typedef struct packed {
		logic [NUM_LAYERS-1:0][5:0] scroll;
		logic [5:0] prio;
		logic [NUM_LAYERS-1:0] dis;
		logic [5:0] back;
		logic [3:0][5:0] px;
		logic [3:0][4:0] py;
	} row_t;

	logic clk;
	logic rst_n;
	logic cpu_we;
	bus_wr_t cpu_wr;
	logic [3:0] red;
	logic [3:0] green;
	logic [3:0] blue;
	logic hsync_n;
	logic vsync_n;
	logic hblank_n;
	logic vblank_n;
	logic csync_n;

	// mirrors of what went over the bus
	logic [3:0] map_m [NUM_LAYERS][MAP_ENTRIES];
	logic [11:0] pal_m [PAL_ENTRIES];
	logic [11:0] frame [V_ACTIVE][H_ACTIVE];

	// per frame counters from the scanner
	int hs_low;
	int vs_low;
	int hb_high;
	int pix_count;
	int dark_bad;
	int csync_bad;
	int errors;
	int checks;
	int tests_run;
	int tests_failed;
	string cur_test;

	////////////////////////////////////////////////////////////
	// test table
	////////////////////////////////////////////////////////////
	// priority byte is {text, fg, bg}, disable bit set turns a layer off
	string names [NUM_ROWS] = '{"all_layers_tie", "bg_only", "bg_scroll", "all_scroll",
		"prio_bg_top", "prio_fg_text_tie", "all_disabled"};
	row_t rows [NUM_ROWS] = '{
		'{scroll: {6'd0, 6'd0, 6'd0}, prio: 6'b00_00_00, dis: 3'b000, back: 6'h00,
			px: {6'd63, 6'd17, 6'd9, 6'd0}, py: {5'd31, 5'd2, 5'd0, 5'd0}},
		'{scroll: {6'd0, 6'd0, 6'd0}, prio: 6'b00_00_00, dis: 3'b110, back: 6'h05,
			px: {6'd62, 6'd33, 6'd8, 6'd0}, py: {5'd30, 5'd15, 5'd8, 5'd0}},
		'{scroll: {6'd0, 6'd0, 6'd13}, prio: 6'b00_00_00, dis: 3'b110, back: 6'h05,
			px: {6'd63, 6'd51, 6'd50, 6'd0}, py: {5'd31, 5'd12, 5'd4, 5'd0}},
		'{scroll: {6'd63, 6'd20, 6'd5}, prio: 6'b00_00_00, dis: 3'b000, back: 6'h00,
			px: {6'd58, 6'd44, 6'd3, 6'd0}, py: {5'd27, 5'd16, 5'd3, 5'd0}},
		'{scroll: {6'd0, 6'd0, 6'd0}, prio: 6'b10_01_11, dis: 3'b000, back: 6'h00,
			px: {6'd40, 6'd17, 6'd9, 6'd0}, py: {5'd20, 5'd2, 5'd0, 5'd0}},
		'{scroll: {6'd0, 6'd0, 6'd0}, prio: 6'b10_10_01, dis: 3'b000, back: 6'h00,
			px: {6'd40, 6'd17, 6'd9, 6'd0}, py: {5'd20, 5'd2, 5'd0, 5'd0}},
		'{scroll: {6'd7, 6'd0, 6'd0}, prio: 6'b00_00_00, dis: 3'b111, back: 6'h2A,
			px: {6'd63, 6'd31, 6'd12, 6'd0}, py: {5'd31, 5'd16, 5'd5, 5'd0}}
	};

	video_board dut (
		.clk(clk),
		.rst_n(rst_n),
		.cpu_we(cpu_we),
		.cpu_wr(cpu_wr),
		.red(red),
		.green(green),
		.blue(blue),
		.hsync_n(hsync_n),
		.vsync_n(vsync_n),
		.hblank_n(hblank_n),
		.vblank_n(vblank_n),
		.csync_n(csync_n)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// bus and memory helpers
	////////////////////////////////////////////////////////////
	task automatic write_bus(input logic [7:0] addr, input logic [11:0] data);
		@(posedge clk);
		#2;
		cpu_we = 1'b1;
		cpu_wr.addr = addr;
		cpu_wr.data = data;
		// write lands on this edge
		@(posedge clk);
		#2;
		cpu_we = 1'b0;
	endtask

	task automatic fill_memories();
		logic [3:0] code;
		for (int l = 0; l < NUM_LAYERS; l++) begin
			for (int i = 0; i < MAP_ENTRIES; i++) begin
				// upper layers get see-through tiles at staggered spots
				if (l != 0 && (i % 5) == l) begin
					code = 4'd0;
				end else begin
					code = 4'($urandom_range(15, 1));
				end
				map_m[l][i] = code;
				write_bus(ADDR_MAP_BASE + 8'(l * MAP_ENTRIES + i), {8'd0, code});
			end
		end
		for (int i = 0; i < PAL_ENTRIES; i++) begin
			pal_m[i] = 12'($urandom);
			write_bus(ADDR_PAL_BASE + 8'(i), pal_m[i]);
		end
	endtask

	task automatic apply_row(input row_t row);
		for (int l = 0; l < NUM_LAYERS; l++) begin
			write_bus(ADDR_SCROLL + 8'(l), {6'd0, row.scroll[l]});
		end
		write_bus(ADDR_PRIORITY, {6'd0, row.prio});
		write_bus(ADDR_DISABLE, {9'd0, row.dis});
		write_bus(ADDR_BACKCOLOR, {6'd0, row.back});
	endtask

	////////////////////////////////////////////////////////////
	// reference pixel
	////////////////////////////////////////////////////////////
	function automatic logic [11:0] model_rgb(input row_t row, input int x, input int y);
		logic [3:0] code [NUM_LAYERS];
		logic [5:0] index;
		int col;
		int best;
		for (int l = 0; l < NUM_LAYERS; l++) begin
			// scroll wraps over the 64 pixel line
			col = (x + int'(row.scroll[l])) % H_ACTIVE;
			if (row.dis[l]) begin
				code[l] = 4'd0;
			end else begin
				code[l] = map_m[l][(y / TILE_H) * TILE_COLS + col / TILE_W];
			end
		end
		// from the top layer down, only a strictly higher priority takes over
		best = -1;
		for (int l = NUM_LAYERS - 1; l >= 0; l--) begin
			if (code[l] != 4'd0) begin
				if (best < 0 || row.prio[2*l +: 2] > row.prio[2*best +: 2]) begin
					best = l;
				end
			end
		end
		if (best < 0) begin
			index = row.back;
		end else begin
			index = {2'(best), code[best]};
		end
		return pal_m[index];
	endfunction

	////////////////////////////////////////////////////////////
	// frame scanner
	////////////////////////////////////////////////////////////
	// outputs move on posedge, sampled on negedge
	task automatic scan_frame();
		logic prev_hb;
		int x;
		int y;
		hs_low = 0;
		vs_low = 0;
		hb_high = 0;
		pix_count = 0;
		dark_bad = 0;
		csync_bad = 0;
		x = 0;
		y = -1;
		prev_hb = 1'b1;
		@(negedge clk);
		// vertical blank first, then its rising end
		while (vblank_n !== 1'b0) begin
			@(negedge clk);
		end
		while (vblank_n !== 1'b1) begin
			prev_hb = hblank_n;
			@(negedge clk);
		end
		for (int n = 0; n < FRAME_CYCLES; n++) begin
			// new line on hblank rising
			if (hblank_n && !prev_hb) begin
				y++;
				x = 0;
			end
			if (!hsync_n) begin
				hs_low++;
			end
			if (!vsync_n) begin
				vs_low++;
			end
			if (hblank_n) begin
				hb_high++;
			end
			if (csync_n !== (hsync_n & vsync_n)) begin
				csync_bad++;
			end
			if (hblank_n && vblank_n) begin
				if (x < H_ACTIVE && y >= 0 && y < V_ACTIVE) begin
					frame[y][x] = {red, green, blue};
				end
				x++;
				pix_count++;
			end else if ({red, green, blue} !== 12'd0) begin
				dark_bad++;
			end
			prev_hb = hblank_n;
			@(negedge clk);
		end
	endtask

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////
	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("mismatch %s %s: expected 'h%0h actual 'h%0h", cur_test, what, expected,
				actual);
		end
	endtask

	task automatic check_row(input row_t row);
		logic [11:0] want;
		int bad;
		int px;
		int py;
		bad = 0;
		// whole picture against the model
		for (int y = 0; y < V_ACTIVE; y++) begin
			for (int x = 0; x < H_ACTIVE; x++) begin
				want = model_rgb(row, x, y);
				if (frame[y][x] !== want) begin
					bad++;
				end
			end
		end
		for (int p = 0; p < 4; p++) begin
			px = int'(row.px[p]);
			py = int'(row.py[p]);
			check_value($sformatf("pixel (%0d,%0d)", px, py), 32'(model_rgb(row, px, py)),
				32'(frame[py][px]));
		end
		check_value("pixels off model", 32'd0, 32'(bad));
		check_value("active pixels", 32'(H_ACTIVE * V_ACTIVE), 32'(pix_count));
		check_value("rgb during blanking", 32'd0, 32'(dark_bad));
		check_value("csync against hsync and vsync", 32'd0, 32'(csync_bad));
	endtask

	task automatic finish_test(input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("test %-18s passed", cur_test);
		end else begin
			tests_failed++;
			$display("test %-18s FAILED", cur_test);
		end
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////
	initial begin
		int err_before;
		void'($urandom(23));
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		rst_n = 1'b0;
		cpu_we = 1'b0;
		cpu_wr = '0;
		repeat (3) @(posedge clk);
		#2;
		// syncs idle and picture dark while in reset
		cur_test = "reset_state";
		err_before = errors;
		check_value("sync pins", 32'h7, 32'({hsync_n, vsync_n, csync_n}));
		check_value("blank pins", 32'h0, 32'({hblank_n, vblank_n}));
		check_value("rgb", 32'h0, 32'({red, green, blue}));
		finish_test(err_before);
		rst_n = 1'b1;

		fill_memories();

		cur_test = "raster_timing";
		err_before = errors;
		scan_frame();
		check_value("hsync low cycles", 32'(H_SYNC * V_TOTAL), 32'(hs_low));
		check_value("vsync low cycles", 32'(V_SYNC * H_TOTAL), 32'(vs_low));
		check_value("hblank high cycles", 32'(H_ACTIVE * V_TOTAL), 32'(hb_high));
		check_value("csync against hsync and vsync", 32'd0, 32'(csync_bad));
		check_value("rgb during blanking", 32'd0, 32'(dark_bad));
		finish_test(err_before);

		for (int r = 0; r < NUM_ROWS; r++) begin
			cur_test = names[r];
			err_before = errors;
			apply_row(rows[r]);
			scan_frame();
			check_row(rows[r]);
			finish_test(err_before);
		end

		$display("tests %0d run, %0d failed, %0d checks, %0d errors", tests_run, tests_failed,
			checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// hang guard, sized from the number of frames the table needs
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, run did not complete", WATCHDOG_NS);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* src/video_board.sv */
`default_nettype none

module video_board import video_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire cpu_we,
	input wire bus_wr_t cpu_wr,
	output logic [3:0] red,
	output logic [3:0] green,
	output logic [3:0] blue,
	output logic hsync_n,
	output logic vsync_n,
	output logic hblank_n,
	output logic vblank_n,
	output logic csync_n
);

	raster_pos_t pos;
	sync_t sync;
	sync_t sync_out;
	logic [NUM_LAYERS-1:0] map_we;
	logic pal_we;
	logic [5:0] wr_addr;
	logic [11:0] wr_data;
	layer_cfg_t [NUM_LAYERS-1:0] layer_cfg;
	logic [5:0] backcolor;
	layer_pix_t [NUM_LAYERS-1:0] pix;
	logic active_d;
	dot_t dot;

	video_timing video_timing (
		.clk(clk),
		.rst_n(rst_n),
		.pos(pos),
		.sync(sync)
	);

	video_regs video_regs (
		.clk(clk),
		.rst_n(rst_n),
		.cpu_we(cpu_we),
		.cpu_wr(cpu_wr),
		.map_we(map_we),
		.pal_we(pal_we),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.layer_cfg(layer_cfg),
		.backcolor(backcolor)
	);

	////////////////////////////////////////////////////////////
	// tilemap layers
	////////////////////////////////////////////////////////////
	// bg, fg, text share the write bus
	for (genvar i = 0; i < NUM_LAYERS; i++) begin : g_layer
		tile_layer tile_layer (
			.clk(clk),
			.rst_n(rst_n),
			.map_we(map_we[i]),
			.wr_addr(wr_addr[MAP_AW-1:0]),
			.wr_data(wr_data[3:0]),
			.pos(pos),
			.cfg(layer_cfg[i]),
			.pix(pix[i])
		);
	end

	// active flag, aligned with the layer pixels
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active_d <= 1'b0;
		end else begin
			active_d <= pos.active;
		end
	end

	layer_mixer layer_mixer (
		.clk(clk),
		.rst_n(rst_n),
		.pix(pix),
		.layer_cfg(layer_cfg),
		.backcolor(backcolor),
		.active_d(active_d),
		.dot(dot)
	);

	palette_out palette_out (
		.clk(clk),
		.rst_n(rst_n),
		.pal_we(pal_we),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.dot(dot),
		.sync_in(sync),
		.red(red),
		.green(green),
		.blue(blue),
		.sync_out(sync_out),
		.csync_n(csync_n)
	);

	// board level sync pins
	assign hsync_n = sync_out.hsync_n;
	assign vsync_n = sync_out.vsync_n;
	assign hblank_n = sync_out.hblank_n;
	assign vblank_n = sync_out.vblank_n;

endmodule

`default_nettype wire

/* src/palette_out.sv */
`default_nettype none

module palette_out import video_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire pal_we,
	input wire [5:0] wr_addr,
	input wire [11:0] wr_data,
	input wire dot_t dot,
	input wire sync_t sync_in,
	output logic [3:0] red,
	output logic [3:0] green,
	output logic [3:0] blue,
	output sync_t sync_out,
	output logic csync_n
);

	// 4 bits each of r, g, b, red on top
	logic [11:0] pal_ram [PAL_ENTRIES];
	logic [11:0] rgb_q;
	sync_t [PIPE_DEPTH-1:0] sync_d;

	always_ff @(posedge clk) begin
		if (pal_we) begin
			pal_ram[wr_addr] <= wr_data;
		end
	end

	////////////////////////////////////////////////////////////
	// colour lookup and sync delay
	////////////////////////////////////////////////////////////
	// sync rides the same three stages as the pixel
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rgb_q <= '0;
			sync_d <= {PIPE_DEPTH{SYNC_RESET}};
		end else begin
			rgb_q <= dot.valid ? pal_ram[dot.index] : '0;
			sync_d <= {sync_d[PIPE_DEPTH-2:0], sync_in};
		end
	end

	assign red = rgb_q[11:8];
	assign green = rgb_q[7:4];
	assign blue = rgb_q[3:0];
	assign sync_out = sync_d[PIPE_DEPTH-1];
	// composite sync, low in either sync
	assign csync_n = sync_out.hsync_n & sync_out.vsync_n;

	// dark whenever the delayed blanking says so
	assert property (@(posedge clk) disable iff (!rst_n)
		!(sync_out.hblank_n && sync_out.vblank_n) |-> (rgb_q == '0));

endmodule

`default_nettype wire

/* src/layer_mixer.sv */
`default_nettype none

module layer_mixer import video_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire layer_pix_t [NUM_LAYERS-1:0] pix,
	input wire layer_cfg_t [NUM_LAYERS-1:0] layer_cfg,
	input wire [5:0] backcolor,
	input wire active_d,
	output dot_t dot
);

	logic found;
	logic [1:0] win_layer;
	logic [1:0] win_prio;
	logic [3:0] win_code;

	////////////////////////////////////////////////////////////
	// priority pick
	////////////////////////////////////////////////////////////
	always_comb begin
		found = 1'b0;
		win_layer = '0;
		win_prio = '0;
		win_code = '0;
		// ascending scan, >= hands a tie to the higher layer
		for (int i = 0; i < NUM_LAYERS; i++) begin
			if (pix[i].code != '0 && (!found || layer_cfg[i].prio >= win_prio)) begin
				found = 1'b1;
				win_layer = 2'(i);
				win_prio = layer_cfg[i].prio;
				win_code = pix[i].code;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// dot register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dot <= '0;
		end else begin
			dot.valid <= active_d;
			// nothing opaque, fall back to back colour
			if (found) begin
				dot.index <= {win_layer, win_code};
			end else begin
				dot.index <= backcolor;
			end
		end
	end

endmodule

`default_nettype wire

/* src/tile_layer.sv */
`default_nettype none

module tile_layer import video_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire map_we,
	input wire [MAP_AW-1:0] wr_addr,
	input wire [3:0] wr_data,
	input wire raster_pos_t pos,
	input wire layer_cfg_t cfg,
	output layer_pix_t pix
);

	// tile code map, one solid code per tile
	logic [3:0] map_ram [MAP_ENTRIES];
	logic [5:0] col;
	logic [MAP_AW-1:0] tile_idx;

	////////////////////////////////////////////////////////////
	// cpu side
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (map_we) begin
			map_ram[wr_addr] <= wr_data;
		end
	end

	////////////////////////////////////////////////////////////
	// pixel fetch
	////////////////////////////////////////////////////////////
	always_comb begin
		// horizontal scroll wraps at 64
		col = pos.h[5:0] + cfg.scroll;
		// 8x8 pixel tiles, row major
		tile_idx = MAP_AW'(int'(pos.v[6:3]) * TILE_COLS + int'(col[5:3]));
	end

	// disabled or blanked reads as transparent
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pix <= '0;
		end else if (cfg.enable && pos.active) begin
			pix.code <= map_ram[tile_idx];
		end else begin
			pix.code <= '0;
		end
	end

endmodule

`default_nettype wire

/* src/video_regs.sv */
`default_nettype none

module video_regs import video_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire cpu_we,
	input wire bus_wr_t cpu_wr,
	output logic [NUM_LAYERS-1:0] map_we,
	output logic pal_we,
	output logic [5:0] wr_addr,
	output logic [11:0] wr_data,
	output layer_cfg_t [NUM_LAYERS-1:0] layer_cfg,
	output logic [5:0] backcolor
);

	logic [7:0] map_off;
	logic [7:0] pal_off;
	logic [7:0] scroll_off;
	logic hit_map;
	logic hit_pal;
	logic hit_scroll;

	////////////////////////////////////////////////////////////
	// address decode
	////////////////////////////////////////////////////////////
	always_comb begin
		map_off = cpu_wr.addr - ADDR_MAP_BASE;
		pal_off = cpu_wr.addr - ADDR_PAL_BASE;
		scroll_off = cpu_wr.addr - ADDR_SCROLL;
		// offsets wrap below the base, so one compare each
		hit_map = map_off < 8'(NUM_LAYERS * MAP_ENTRIES);
		hit_pal = pal_off < 8'(PAL_ENTRIES);
		hit_scroll = scroll_off < 8'(NUM_LAYERS);
	end

	// ram strobes, same edge as cpu_we
	always_comb begin
		for (int i = 0; i < NUM_LAYERS; i++) begin
			map_we[i] = cpu_we && hit_map && (int'(map_off) / MAP_ENTRIES == i);
		end
		pal_we = cpu_we && hit_pal;
		// index within the selected ram
		if (hit_pal) begin
			wr_addr = pal_off[5:0];
		end else begin
			wr_addr = {1'b0, map_off[4:0]};
		end
		wr_data = cpu_wr.data;
	end

	////////////////////////////////////////////////////////////
	// control registers
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_LAYERS; i++) begin
				layer_cfg[i].scroll <= '0;
				layer_cfg[i].prio <= '0;
				layer_cfg[i].enable <= 1'b1;
			end
			backcolor <= '0;
		end else if (cpu_we) begin
			// one scroll register per layer
			if (hit_scroll) begin
				layer_cfg[scroll_off[1:0]].scroll <= cpu_wr.data[5:0];
			end
			// two priority bits per layer, layer 0 lowest
			if (cpu_wr.addr == ADDR_PRIORITY) begin
				for (int i = 0; i < NUM_LAYERS; i++) begin
					layer_cfg[i].prio <= cpu_wr.data[2*i +: 2];
				end
			end
			// set bit turns the layer off
			if (cpu_wr.addr == ADDR_DISABLE) begin
				for (int i = 0; i < NUM_LAYERS; i++) begin
					layer_cfg[i].enable <= !cpu_wr.data[i];
				end
			end
			if (cpu_wr.addr == ADDR_BACKCOLOR) begin
				backcolor <= cpu_wr.data[5:0];
			end
		end
	end

	// one ram per write, palette never with a map
	assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({map_we, pal_we}));

endmodule

`default_nettype wire

/* src/video_timing.sv */
`default_nettype none

module video_timing import video_pkg::*; (
	input wire clk,
	input wire rst_n,
	output raster_pos_t pos,
	output sync_t sync
);

	logic [6:0] h_nxt;
	logic [6:0] v_nxt;
	logic h_sync_zone;
	logic v_sync_zone;

	////////////////////////////////////////////////////////////
	// next raster position
	////////////////////////////////////////////////////////////
	always_comb begin
		h_nxt = pos.h + 7'd1;
		v_nxt = pos.v;
		// step the line counter at the end of a line
		if (pos.h == 7'(H_TOTAL - 1)) begin
			h_nxt = '0;
			if (pos.v == 7'(V_TOTAL - 1)) begin
				v_nxt = '0;
			end else begin
				v_nxt = pos.v + 7'd1;
			end
		end
	end

	// sync windows sit after the front porch
	always_comb begin
		h_sync_zone = (h_nxt >= 7'(H_ACTIVE + H_FRONT)) &&
			(h_nxt < 7'(H_ACTIVE + H_FRONT + H_SYNC));
		v_sync_zone = (v_nxt >= 7'(V_ACTIVE + V_FRONT)) &&
			(v_nxt < 7'(V_ACTIVE + V_FRONT + V_SYNC));
	end

	////////////////////////////////////////////////////////////
	// counters and decoded flags
	////////////////////////////////////////////////////////////
	// flags decoded from next position so they line up with pos
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pos <= '0;
			sync <= SYNC_RESET;
		end else begin
			pos.h <= h_nxt;
			pos.v <= v_nxt;
			pos.active <= (h_nxt < 7'(H_ACTIVE)) && (v_nxt < 7'(V_ACTIVE));
			sync.hsync_n <= !h_sync_zone;
			sync.vsync_n <= !v_sync_zone;
			sync.hblank_n <= h_nxt < 7'(H_ACTIVE);
			sync.vblank_n <= v_nxt < 7'(V_ACTIVE);
		end
	end

	// counters stay inside the raster
	assert property (@(posedge clk) disable iff (!rst_n)
		(pos.h < 7'(H_TOTAL)) && (pos.v < 7'(V_TOTAL)));

endmodule

`default_nettype wire

/* src/video_pkg.sv */
`default_nettype none

package video_pkg;

	////////////////////////////////////////////////////////////
	// raster geometry, one clk per pixel
	////////////////////////////////////////////////////////////
	localparam int H_ACTIVE = 64;
	localparam int H_FRONT = 4;
	localparam int H_SYNC = 6;
	localparam int H_TOTAL = 80;
	localparam int V_ACTIVE = 32;
	localparam int V_FRONT = 2;
	localparam int V_SYNC = 2;
	localparam int V_TOTAL = 40;

	// layer 0 background, 1 foreground, 2 text
	localparam int NUM_LAYERS = 3;
	localparam int TILE_COLS = 8;
	localparam int TILE_ROWS = 4;
	localparam int MAP_ENTRIES = TILE_COLS * TILE_ROWS;
	localparam int MAP_AW = $clog2(MAP_ENTRIES);
	localparam int PAL_ENTRIES = 64;
	// timing -> layer -> mixer -> palette
	localparam int PIPE_DEPTH = 3;

	////////////////////////////////////////////////////////////
	// cpu address map
	////////////////////////////////////////////////////////////
	localparam logic [7:0] ADDR_MAP_BASE = 8'h00;
	localparam logic [7:0] ADDR_PAL_BASE = 8'h80;
	localparam logic [7:0] ADDR_SCROLL = 8'hC0;
	localparam logic [7:0] ADDR_PRIORITY = 8'hC4;
	localparam logic [7:0] ADDR_BACKCOLOR = 8'hC5;
	localparam logic [7:0] ADDR_DISABLE = 8'hC6;

	// one cpu write
	typedef struct packed {
		logic [7:0] addr;
		logic [11:0] data;
	} bus_wr_t;

	typedef struct packed {
		logic [6:0] h;
		logic [6:0] v;
		logic active;
	} raster_pos_t;

	// all active low
	typedef struct packed {
		logic hsync_n;
		logic vsync_n;
		logic hblank_n;
		logic vblank_n;
	} sync_t;

	typedef struct packed {
		logic [5:0] scroll;
		logic [1:0] prio;
		logic enable;
	} layer_cfg_t;

	// code 0 is see-through
	typedef struct packed {
		logic [3:0] code;
	} layer_pix_t;

	// index is layer in [5:4], code in [3:0]
	typedef struct packed {
		logic valid;
		logic [5:0] index;
	} dot_t;

	// syncs idle, picture blanked
	localparam sync_t SYNC_RESET = '{hsync_n: 1'b1, vsync_n: 1'b1, hblank_n: 1'b0, vblank_n: 1'b0};

endpackage

`default_nettype wire
